// File: include/rv_core_cfg.svh
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// --------------------
// architectural widths
// --------------------
`define RV_XLEN         32
`define RV_REG_ADDR_W   5
`define RV_REG_COUNT    32

// shift amount, low bits of operand b
`define RV_SHAMT_W      5

// instruction field widths
`define RV_OPC_W        7
`define RV_F3_W         3
`define RV_F7_W         7
`define RV_IMM_W        12

// --------------------
// opcodes
// --------------------
`define RV_OPC_OP       7'b0110011
`define RV_OPC_OP_IMM   7'b0010011

// --------------------
// funct3 codes
// --------------------
`define RV_F3_ADD_SUB   3'b000
`define RV_F3_SLL       3'b001
`define RV_F3_SLT       3'b010
`define RV_F3_SLTU      3'b011
`define RV_F3_XOR       3'b100
`define RV_F3_SRL_SRA   3'b101
`define RV_F3_OR        3'b110
`define RV_F3_AND       3'b111

// funct7, alt selects sub and sra
`define RV_F7_BASE      7'b0000000
`define RV_F7_ALT       7'b0100000

`endif

// File: verilog/rv_core_pkg.sv
`include "rv_core_cfg.svh"

package rv_core_pkg;

    // --------------------
    // basic words
    // --------------------

    // one data word of the integer datapath
    typedef logic [`RV_XLEN-1:0] word_t;

    // register file index, x0 to x31
    typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

    // --------------------
    // alu operations
    // --------------------

    // immediate forms map onto the same ops
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_t;

    // --------------------
    // instruction views
    // --------------------

    // register-register format
    typedef struct packed {
        logic [`RV_F7_W-1:0]  funct7;
        reg_addr_t            rs2;
        reg_addr_t            rs1;
        logic [`RV_F3_W-1:0]  funct3;
        reg_addr_t            rd;
        logic [`RV_OPC_W-1:0] opcode;
    } inst_r_t;

    // register-immediate format
    // imm12 overlays funct7 and rs2 of the r view
    typedef struct packed {
        logic [`RV_IMM_W-1:0] imm12;
        reg_addr_t            rs1;
        logic [`RV_F3_W-1:0]  funct3;
        reg_addr_t            rd;
        logic [`RV_OPC_W-1:0] opcode;
    } inst_i_t;

    // one word, two decodes
    // rs1, funct3, rd and opcode sit at the same bits in both
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_u;

endpackage

// File: verilog/rv_reg_file.sv
`include "rv_core_cfg.svh"

module rv_reg_file (
    input  logic                   clk,
    input  logic                   rst,
    input  rv_core_pkg::reg_addr_t rs1_addr_i,
    input  rv_core_pkg::reg_addr_t rs2_addr_i,
    input  logic                   we_i,
    input  rv_core_pkg::reg_addr_t rd_i,
    input  rv_core_pkg::word_t     rd_data_i,
    output rv_core_pkg::word_t     rs1_data_o,
    output rv_core_pkg::word_t     rs2_data_o
);

    // x1..x31, x0 has no storage
    rv_core_pkg::word_t regs [1:`RV_REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (rd_i != '0)) begin
            regs[rd_i] <= rd_data_i;
        end
    end

    // write-first, covers distance-two dependences
    function automatic rv_core_pkg::word_t read_port(input rv_core_pkg::reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (we_i && (addr == rd_i)) begin
            return rd_data_i;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
    end

    // a write shows up on the next read of that register, x0 stays zero
    a_write_read_back: assert property (
        @(posedge clk) disable iff (rst)
        we_i |=> ((rs1_addr_i != $past(rd_i))
                  || (we_i && (rd_i == rs1_addr_i) && (rd_i != '0))
                  || (rs1_data_o == (($past(rd_i) == '0) ? '0 : $past(rd_data_i))))
    );

endmodule

// File: verilog/rv_decode_stage.sv
`include "rv_core_cfg.svh"

module rv_decode_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  inst_valid_i,
    input  rv_core_pkg::word_t    inst_i,
    input  rv_core_pkg::word_t    rs1_data_i,
    input  rv_core_pkg::word_t    rs2_data_i,
    output rv_core_pkg::reg_addr_t rs1_addr_o,
    output rv_core_pkg::reg_addr_t rs2_addr_o,
    output logic                  ex_valid_o,
    output rv_core_pkg::alu_op_t  ex_op_o,
    output rv_core_pkg::reg_addr_t ex_rd_o,
    output rv_core_pkg::reg_addr_t ex_rs1_o,
    output rv_core_pkg::reg_addr_t ex_rs2_o,
    output rv_core_pkg::word_t    ex_a_o,
    output rv_core_pkg::word_t    ex_b_o,
    output logic                  ex_use_imm_o,
    output rv_core_pkg::word_t    ex_imm_o
);

    // --------------------
    // accepted word
    // --------------------
    rv_core_pkg::inst_u inst_q;
    logic               inst_valid_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            inst_valid_q <= 1'b0;
        end else begin
            inst_valid_q <= inst_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        inst_q <= rv_core_pkg::inst_u'(inst_i);
    end

    // --------------------
    // decode
    // --------------------
    logic                 is_r;
    logic                 is_i;
    logic                 f7_base;
    logic                 f7_alt;
    logic                 f7_ok;
    logic                 dec_legal;
    rv_core_pkg::alu_op_t dec_op;
    rv_core_pkg::word_t   dec_imm;

    always_comb begin
        is_r    = (inst_q.r.opcode == `RV_OPC_OP);
        is_i    = (inst_q.i.opcode == `RV_OPC_OP_IMM);
        f7_base = (inst_q.r.funct7 == `RV_F7_BASE);
        f7_alt  = (inst_q.r.funct7 == `RV_F7_ALT);
        dec_op  = rv_core_pkg::ALU_ADD;
        f7_ok   = 1'b0;
        // funct7 only matters for r-type and the immediate shifts
        case (inst_q.r.funct3)
            `RV_F3_ADD_SUB: begin
                dec_op = (is_r && f7_alt) ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
                f7_ok  = is_i || f7_base || f7_alt;
            end
            `RV_F3_SLL: begin
                dec_op = rv_core_pkg::ALU_SLL;
                f7_ok  = f7_base;
            end
            `RV_F3_SLT: begin
                dec_op = rv_core_pkg::ALU_SLT;
                f7_ok  = is_i || f7_base;
            end
            `RV_F3_SLTU: begin
                dec_op = rv_core_pkg::ALU_SLTU;
                f7_ok  = is_i || f7_base;
            end
            `RV_F3_XOR: begin
                dec_op = rv_core_pkg::ALU_XOR;
                f7_ok  = is_i || f7_base;
            end
            `RV_F3_SRL_SRA: begin
                // srai carries the alt pattern in imm[11:5]
                dec_op = f7_alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
                f7_ok  = f7_base || f7_alt;
            end
            `RV_F3_OR: begin
                dec_op = rv_core_pkg::ALU_OR;
                f7_ok  = is_i || f7_base;
            end
            `RV_F3_AND: begin
                dec_op = rv_core_pkg::ALU_AND;
                f7_ok  = is_i || f7_base;
            end
        endcase
        dec_legal = (is_r || is_i) && f7_ok;
    end

    // sign-extended imm12
    assign dec_imm = {{(`RV_XLEN-`RV_IMM_W){inst_q.i.imm12[`RV_IMM_W-1]}}, inst_q.i.imm12};

    // register file read, same cycle
    assign rs1_addr_o = inst_q.r.rs1;
    assign rs2_addr_o = inst_q.r.rs2;

    // --------------------
    // decode/execute regs
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid_o <= 1'b0;
        end else begin
            // unsupported encodings leave as bubbles
            ex_valid_o <= inst_valid_q && dec_legal;
        end
    end

    always_ff @(posedge clk) begin
        ex_op_o      <= dec_op;
        ex_rd_o      <= inst_q.r.rd;
        ex_rs1_o     <= inst_q.r.rs1;
        // no rs2 source for i-type
        ex_rs2_o     <= is_i ? '0 : inst_q.r.rs2;
        ex_a_o       <= rs1_data_i;
        ex_b_o       <= rs2_data_i;
        ex_use_imm_o <= is_i;
        ex_imm_o     <= dec_imm;
    end

    a_ex_op_legal: assert property (
        @(posedge clk) disable iff (rst)
        ex_valid_o |-> (ex_op_o <= rv_core_pkg::ALU_AND)
    );

endmodule

// File: verilog/rv_execute_stage.sv
`include "rv_core_cfg.svh"

module rv_execute_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   ex_valid_i,
    input  rv_core_pkg::alu_op_t   ex_op_i,
    input  rv_core_pkg::reg_addr_t ex_rd_i,
    input  rv_core_pkg::reg_addr_t ex_rs1_i,
    input  rv_core_pkg::reg_addr_t ex_rs2_i,
    input  rv_core_pkg::word_t     ex_a_i,
    input  rv_core_pkg::word_t     ex_b_i,
    input  logic                   ex_use_imm_i,
    input  rv_core_pkg::word_t     ex_imm_i,
    output logic                   wb_valid_o,
    output rv_core_pkg::reg_addr_t wb_rd_o,
    output rv_core_pkg::word_t     wb_data_o
);

    // --------------------
    // operand forwarding
    // --------------------
    rv_core_pkg::word_t op_a;
    rv_core_pkg::word_t rs2_val;
    rv_core_pkg::word_t op_b;

    // distance one, from our own writeback reg
    function automatic rv_core_pkg::word_t fwd(
        input rv_core_pkg::reg_addr_t src,
        input rv_core_pkg::word_t     rf_val
    );
        if (wb_valid_o && (wb_rd_o != '0) && (wb_rd_o == src)) begin
            return wb_data_o;
        end
        return rf_val;
    endfunction

    always_comb begin
        op_a    = fwd(ex_rs1_i, ex_a_i);
        rs2_val = fwd(ex_rs2_i, ex_b_i);
        op_b    = ex_use_imm_i ? ex_imm_i : rs2_val;
    end

    // --------------------
    // alu
    // --------------------
    logic [`RV_SHAMT_W-1:0] shamt;
    logic                   lt_s;
    logic                   lt_u;
    rv_core_pkg::word_t     alu_res;

    assign shamt = op_b[`RV_SHAMT_W-1:0];
    assign lt_s  = ($signed(op_a) < $signed(op_b));
    assign lt_u  = (op_a < op_b);

    always_comb begin
        case (ex_op_i)
            rv_core_pkg::ALU_ADD:  alu_res = op_a + op_b;
            rv_core_pkg::ALU_SUB:  alu_res = op_a - op_b;
            rv_core_pkg::ALU_SLL:  alu_res = op_a << shamt;
            rv_core_pkg::ALU_SLT:  alu_res = {{(`RV_XLEN-1){1'b0}}, lt_s};
            rv_core_pkg::ALU_SLTU: alu_res = {{(`RV_XLEN-1){1'b0}}, lt_u};
            rv_core_pkg::ALU_XOR:  alu_res = op_a ^ op_b;
            rv_core_pkg::ALU_SRL:  alu_res = op_a >> shamt;
            // arithmetic, sign bit fills from the left
            rv_core_pkg::ALU_SRA:  alu_res = rv_core_pkg::word_t'($signed(op_a) >>> shamt);
            rv_core_pkg::ALU_OR:   alu_res = op_a | op_b;
            rv_core_pkg::ALU_AND:  alu_res = op_a & op_b;
            default:               alu_res = '0;
        endcase
    end

    // --------------------
    // writeback regs
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= ex_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_o   <= ex_rd_i;
        wb_data_o <= alu_res;
    end

    // drives both the rf write enable and the forward select
    a_wb_valid_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(wb_valid_o)
    );

endmodule

// File: verilog/rv_core.sv
module rv_core (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   inst_valid_i,
    input  rv_core_pkg::word_t     inst_i,
    output logic                   retire_valid_o,
    output rv_core_pkg::reg_addr_t retire_rd_o,
    output rv_core_pkg::word_t     retire_data_o
);

    // decode <-> register file
    rv_core_pkg::reg_addr_t rs1_addr;
    rv_core_pkg::reg_addr_t rs2_addr;
    rv_core_pkg::word_t     rs1_data;
    rv_core_pkg::word_t     rs2_data;

    // decode -> execute
    logic                   ex_valid;
    rv_core_pkg::alu_op_t   ex_op;
    rv_core_pkg::reg_addr_t ex_rd;
    rv_core_pkg::reg_addr_t ex_rs1;
    rv_core_pkg::reg_addr_t ex_rs2;
    rv_core_pkg::word_t     ex_a;
    rv_core_pkg::word_t     ex_b;
    logic                   ex_use_imm;
    rv_core_pkg::word_t     ex_imm;

    // writeback, also the retire report
    logic                   wb_valid;
    rv_core_pkg::reg_addr_t wb_rd;
    rv_core_pkg::word_t     wb_data;

    rv_decode_stage i_rv_decode_stage (
        .clk          (clk),
        .rst          (rst),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .ex_valid_o   (ex_valid),
        .ex_op_o      (ex_op),
        .ex_rd_o      (ex_rd),
        .ex_rs1_o     (ex_rs1),
        .ex_rs2_o     (ex_rs2),
        .ex_a_o       (ex_a),
        .ex_b_o       (ex_b),
        .ex_use_imm_o (ex_use_imm),
        .ex_imm_o     (ex_imm)
    );

    rv_reg_file i_rv_reg_file (
        .clk        (clk),
        .rst        (rst),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .we_i       (wb_valid),
        .rd_i       (wb_rd),
        .rd_data_i  (wb_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    rv_execute_stage i_rv_execute_stage (
        .clk          (clk),
        .rst          (rst),
        .ex_valid_i   (ex_valid),
        .ex_op_i      (ex_op),
        .ex_rd_i      (ex_rd),
        .ex_rs1_i     (ex_rs1),
        .ex_rs2_i     (ex_rs2),
        .ex_a_i       (ex_a),
        .ex_b_i       (ex_b),
        .ex_use_imm_i (ex_use_imm),
        .ex_imm_i     (ex_imm),
        .wb_valid_o   (wb_valid),
        .wb_rd_o      (wb_rd),
        .wb_data_o    (wb_data)
    );

    assign retire_valid_o = wb_valid;
    assign retire_rd_o    = wb_rd;
    assign retire_data_o  = wb_data;

endmodule

// File: include/rv_core_tb_vectors.svh
`ifndef RV_CORE_TB_VECTORS_SVH
`define RV_CORE_TB_VECTORS_SVH

// columns: valid, instruction word, retires, expected rd, expected data
// one row per cycle, checked when the row reaches writeback

// i-type from x0, sign-extended immediates
add_row(1'b1, encode_i(`RV_F3_ADD_SUB, 5'd1, 5'd0, 12'hffb), 1'b1, 5'd1, 32'hffff_fffb);
add_row(1'b1, encode_i(`RV_F3_XOR, 5'd2, 5'd0, 12'hf00), 1'b1, 5'd2, 32'hffff_ff00);
add_row(1'b1, encode_i(`RV_F3_OR, 5'd3, 5'd0, 12'h7ff), 1'b1, 5'd3, 32'h0000_07ff);
add_row(1'b1, encode_i(`RV_F3_AND, 5'd4, 5'd0, 12'hfff), 1'b1, 5'd4, 32'h0000_0000);
add_row(1'b1, encode_i(`RV_F3_ADD_SUB, 5'd5, 5'd0, 12'd100), 1'b1, 5'd5, 32'h0000_0064);
add_row(1'b1, encode_i(`RV_F3_ADD_SUB, 5'd6, 5'd0, 12'd7), 1'b1, 5'd6, 32'h0000_0007);
// sub x7,x6,x5 reads x6 at distance one and x5 at distance two
add_row(1'b1, encode_r(`RV_F7_ALT, `RV_F3_ADD_SUB, 5'd7, 5'd6, 5'd5), 1'b1, 5'd7, 32'hffff_ffa3);
add_row(1'b1, encode_r(`RV_F7_BASE, `RV_F3_ADD_SUB, 5'd8, 5'd7, 5'd1), 1'b1, 5'd8, 32'hffff_ff9e);
// 0 - 100 wraps
add_row(1'b1, encode_r(`RV_F7_ALT, `RV_F3_ADD_SUB, 5'd9, 5'd0, 5'd5), 1'b1, 5'd9, 32'hffff_ff9c);
// valid low, then a load and a mul, none of them retire
add_row(1'b0, encode_i(`RV_F3_ADD_SUB, 5'd10, 5'd0, 12'd1), 1'b0, 5'd0, 32'h0);
add_row(1'b1, 32'h0000_2583, 1'b0, 5'd0, 32'h0);
add_row(1'b1, encode_r(7'b0000001, `RV_F3_ADD_SUB, 5'd12, 5'd1, 5'd1), 1'b0, 5'd0, 32'h0);
// logic ops on loaded registers
add_row(1'b1, encode_r(`RV_F7_BASE, `RV_F3_XOR, 5'd10, 5'd2, 5'd3), 1'b1, 5'd10, 32'hffff_f8ff);
add_row(1'b1, encode_r(`RV_F7_BASE, `RV_F3_OR, 5'd11, 5'd1, 5'd3), 1'b1, 5'd11, 32'hffff_ffff);
add_row(1'b1, encode_r(`RV_F7_BASE, `RV_F3_AND, 5'd12, 5'd2, 5'd3), 1'b1, 5'd12, 32'h0000_0700);
// sra against srl on a negative value
add_row(1'b1, encode_r(`RV_F7_ALT, `RV_F3_SRL_SRA, 5'd13, 5'd2, 5'd6), 1'b1, 5'd13, 32'hffff_fffe);
add_row(1'b1, encode_r(`RV_F7_BASE, `RV_F3_SRL_SRA, 5'd14, 5'd2, 5'd6), 1'b1, 5'd14, 32'h01ff_fffe);
// slt against sltu, -5 and 7
add_row(1'b1, encode_r(`RV_F7_BASE, `RV_F3_SLT, 5'd15, 5'd1, 5'd6), 1'b1, 5'd15, 32'h0000_0001);
add_row(1'b1, encode_r(`RV_F7_BASE, `RV_F3_SLTU, 5'd16, 5'd1, 5'd6), 1'b1, 5'd16, 32'h0000_0000);
// immediate shifts
add_row(1'b1, encode_i(`RV_F3_SLL, 5'd17, 5'd6, {`RV_F7_BASE, 5'd4}), 1'b1, 5'd17, 32'h0000_0070);
add_row(1'b1, encode_i(`RV_F3_SRL_SRA, 5'd18, 5'd2, {`RV_F7_BASE, 5'd8}), 1'b1, 5'd18, 32'h00ff_ffff);
add_row(1'b1, encode_i(`RV_F3_SRL_SRA, 5'd19, 5'd2, {`RV_F7_ALT, 5'd8}), 1'b1, 5'd19, 32'hffff_ffff);
add_row(1'b1, encode_r(`RV_F7_BASE, `RV_F3_SLL, 5'd20, 5'd5, 5'd6), 1'b1, 5'd20, 32'h0000_3200);
add_row(1'b1, encode_i(`RV_F3_SLT, 5'd21, 5'd1, 12'hffc), 1'b1, 5'd21, 32'h0000_0001);
add_row(1'b1, encode_i(`RV_F3_SLTU, 5'd22, 5'd6, 12'hfff), 1'b1, 5'd22, 32'h0000_0001);
// x23 written twice, later reads must see the second value
add_row(1'b1, encode_i(`RV_F3_ADD_SUB, 5'd23, 5'd0, 12'd10), 1'b1, 5'd23, 32'h0000_000a);
add_row(1'b1, encode_i(`RV_F3_ADD_SUB, 5'd23, 5'd23, 12'd5), 1'b1, 5'd23, 32'h0000_000f);
add_row(1'b1, encode_r(`RV_F7_BASE, `RV_F3_ADD_SUB, 5'd24, 5'd23, 5'd23), 1'b1, 5'd24, 32'h0000_001e);
add_row(1'b1, encode_r(`RV_F7_BASE, `RV_F3_ADD_SUB, 5'd25, 5'd23, 5'd24), 1'b1, 5'd25, 32'h0000_002d);
add_row(1'b1, encode_r(`RV_F7_ALT, `RV_F3_ADD_SUB, 5'd26, 5'd25, 5'd23), 1'b1, 5'd26, 32'h0000_001e);
// write to x0 retires with rd 0, later reads of x0 stay zero
add_row(1'b1, encode_i(`RV_F3_ADD_SUB, 5'd0, 5'd0, 12'd55), 1'b1, 5'd0, 32'h0000_0037);
add_row(1'b1, encode_r(`RV_F7_BASE, `RV_F3_ADD_SUB, 5'd27, 5'd0, 5'd0), 1'b1, 5'd27, 32'h0000_0000);
add_row(1'b1, encode_r(`RV_F7_BASE, `RV_F3_OR, 5'd28, 5'd0, 5'd6), 1'b1, 5'd28, 32'h0000_0007);
add_row(1'b0, 32'h0000_0000, 1'b0, 5'd0, 32'h0);
add_row(1'b1, encode_i(`RV_F3_ADD_SUB, 5'd29, 5'd27, 12'hfff), 1'b1, 5'd29, 32'hffff_ffff);
add_row(1'b1, encode_r(`RV_F7_ALT, `RV_F3_ADD_SUB, 5'd30, 5'd29, 5'd1), 1'b1, 5'd30, 32'h0000_0004);
add_row(1'b1, encode_r(`RV_F7_ALT, `RV_F3_ADD_SUB, 5'd31, 5'd1, 5'd29), 1'b1, 5'd31, 32'hffff_fffc);

`endif

// File: test/rv_core_tb.sv
`include "rv_core_cfg.svh"

module rv_core_tb;

    localparam int RESET_CYCLES   = 5;
    // a row retires two loop passes after the pass that drove it
    localparam int CHECK_LAG      = 2;
    localparam int TIMEOUT_MARGIN = 20;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   inst_valid_i;
    rv_core_pkg::word_t     inst_i;
    logic                   retire_valid_o;
    rv_core_pkg::reg_addr_t retire_rd_o;
    rv_core_pkg::word_t     retire_data_o;

    // stimulus table, one column per queue
    logic                   row_valid  [$];
    rv_core_pkg::word_t     row_inst   [$];
    logic                   row_retire [$];
    rv_core_pkg::reg_addr_t row_rd     [$];
    rv_core_pkg::word_t     row_data   [$];

    int error_count   = 0;
    int cycle_count   = 0;
    int timeout_limit = 0;

    rv_core i_rv_core (
        .clk            (clk),
        .rst            (rst),
        .inst_valid_i   (inst_valid_i),
        .inst_i         (inst_i),
        .retire_valid_o (retire_valid_o),
        .retire_rd_o    (retire_rd_o),
        .retire_data_o  (retire_data_o)
    );

    always #2 clk = ~clk;

    // --------------------
    // timeout
    // --------------------
    always @(posedge clk) begin
        if (!rst && (timeout_limit > 0)) begin
            cycle_count++;
            if (cycle_count > timeout_limit) begin
                $display("STATUS: FAIL");
                $fatal(1, "timeout: table not finished within %0d cycles", timeout_limit);
            end
        end
    end

    // --------------------
    // instruction encoding
    // --------------------
    function automatic rv_core_pkg::word_t encode_i(
        input logic [2:0]             f3,
        input rv_core_pkg::reg_addr_t rd,
        input rv_core_pkg::reg_addr_t rs1,
        input logic [11:0]            imm
    );
        return {imm, rs1, f3, rd, `RV_OPC_OP_IMM};
    endfunction

    function automatic rv_core_pkg::word_t encode_r(
        input logic [6:0]             f7,
        input logic [2:0]             f3,
        input rv_core_pkg::reg_addr_t rd,
        input rv_core_pkg::reg_addr_t rs1,
        input rv_core_pkg::reg_addr_t rs2
    );
        return {f7, rs2, rs1, f3, rd, `RV_OPC_OP};
    endfunction

    task automatic add_row(
        input logic                   valid,
        input rv_core_pkg::word_t     inst,
        input logic                   retire,
        input rv_core_pkg::reg_addr_t rd,
        input rv_core_pkg::word_t     data
    );
        row_valid.push_back(valid);
        row_inst.push_back(inst);
        row_retire.push_back(retire);
        row_rd.push_back(rd);
        row_data.push_back(data);
    endtask

    task automatic load_table();
        `include "rv_core_tb_vectors.svh"
    endtask

    // --------------------
    // compare tasks
    // --------------------
    task automatic abort_on_error();
        $display("STATUS: FAIL");
        $fatal(1, "stopping at the first mismatch");
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            error_count++;
            $display("ERROR: t=%0t %s expected %b actual %b", $time, name, expected, actual);
            abort_on_error();
        end
    endtask

    task automatic check_reg_addr(
        input string                  name,
        input rv_core_pkg::reg_addr_t actual,
        input rv_core_pkg::reg_addr_t expected
    );
        if (actual !== expected) begin
            error_count++;
            $display("ERROR: t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
            abort_on_error();
        end
    endtask

    task automatic check_word(
        input string              name,
        input rv_core_pkg::word_t actual,
        input rv_core_pkg::word_t expected
    );
        if (actual !== expected) begin
            error_count++;
            $display("ERROR: t=%0t %s expected 0x%h actual 0x%h", $time, name, expected, actual);
            abort_on_error();
        end
    endtask

    // --------------------
    // table loop
    // --------------------
    task automatic drive_row(input int n);
        if (n < row_valid.size()) begin
            inst_valid_i = row_valid[n];
            inst_i       = row_inst[n];
        end else begin
            inst_valid_i = 1'b0;
            inst_i       = '0;
        end
    endtask

    task automatic check_row(input int n);
        check_bit("retire_valid_o", retire_valid_o, row_retire[n]);
        if (row_retire[n]) begin
            check_reg_addr("retire_rd_o", retire_rd_o, row_rd[n]);
            check_word("retire_data_o", retire_data_o, row_data[n]);
        end
    endtask

    initial begin
        rst          = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        load_table();
        timeout_limit = row_valid.size() + TIMEOUT_MARGIN;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int n = 0; n < row_valid.size() + CHECK_LAG; n++) begin
            drive_row(n);
            @(posedge clk);
            #1;
            if (n >= CHECK_LAG) begin
                check_row(n - CHECK_LAG);
            end
        end

        if (error_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("STATUS: FAIL");
            $fatal(1, "%0d mismatches in the table", error_count);
        end
    end

endmodule

// File: sources.f
+incdir+include
verilog/rv_core_pkg.sv
verilog/rv_reg_file.sv
verilog/rv_decode_stage.sv
verilog/rv_execute_stage.sv
verilog/rv_core.sv
test/rv_core_tb.sv

// File: Makefile
SIM      := verilator
TOP      := rv_core_tb
FILELIST := sources.f
OBJ_DIR  := obj_dir
FLAGS    := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# exit status of the simulation is the pass or fail result
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
